// ==== src.f ====
rtl/opp_cfg_pkg.sv
rtl/opp_data_pkg.sv
rtl/opp_cfg_if.sv
rtl/opp_stage_if.sv
rtl/opp_cfg_regs.sv
rtl/opp_sequencer.sv
rtl/opp_gain_stage.sv
rtl/opp_accum_stage.sv
rtl/output_preprocessor.sv
verification/tb_clock_gen.sv
verification/tb_output_preprocessor.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_output_preprocessor
FILELIST = src.f
BUILD    = obj_dir
PASS_MSG = Test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// ==== verification/tb_output_preprocessor.sv ====
`default_nettype none

module tb_output_preprocessor;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int w_in = 18;
	localparam int w_out = 16;
	localparam int comp_latency = 3;
	localparam int omax_init = 9999;
	localparam int omin_init = 1111;
	localparam int oinit_init = 5000;
	localparam int mult_init = 1;
	localparam int out_hi = (1 << (w_out - 1)) - 1;	// signed output range
	localparam int out_lo = -(1 << (w_out - 1));
	localparam int n_samples = 240;	// upper estimate of samples sent
	localparam int n_axi = 70;	// upper estimate of axi transfers
	localparam int cycle_limit = n_samples * (comp_latency + 4) + n_axi * 6 + 100;
	localparam logic [1:0] okay = opp_cfg_pkg::resp_okay;
	localparam logic [1:0] slverr = opp_cfg_pkg::resp_slverr;

	logic clk_in, reset_in;
	logic signed [w_in-1:0] data_in;
	logic data_valid_in, data_ready_out, lock_en_in;
	logic signed [w_out-1:0] data_out;
	logic data_valid_out;
	logic [opp_cfg_pkg::axi_addr_w-1:0] s_axi_awaddr, s_axi_araddr;
	logic [opp_cfg_pkg::axi_data_w-1:0] s_axi_wdata, s_axi_rdata;
	logic [opp_cfg_pkg::axi_data_w/8-1:0] s_axi_wstrb;
	logic s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
	logic [1:0] s_axi_bresp, s_axi_rresp;
	logic s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
	logic s_axi_rvalid, s_axi_rready;

	// model of staged and active configuration
	int stg_max = omax_init, stg_min = omin_init, stg_init = oinit_init, stg_mult = mult_init;
	int act_max = omax_init, act_min = omin_init, act_init = oinit_init, act_mult = mult_init;
	int prev_model = oinit_init;	// last emitted output

	int cycle = 0;	// rising edges so far
	int t0;	// acceptance edge of sample in flight
	bit in_flight = 1'b0;
	int cap_sample;
	bit cap_lock;
	int n_acc = 0, n_out = 0;
	int last_out;	// data_out seen at last valid

	tb_clock_gen u_clock_gen (.clk_in, .reset_in);

	output_preprocessor #(
		.w_in(w_in), .w_out(w_out), .comp_latency(comp_latency),
		.omax_init(omax_init), .omin_init(omin_init),
		.oinit_init(oinit_init), .mult_init(mult_init)
	) DUT (.*);

	//////////////////////////////////////////////////
	// checks and reference model
	//////////////////////////////////////////////////

	task automatic check_value(input string name, input logic signed [31:0] got,
		input logic signed [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	function automatic int saturate(input int value);
		if (value > out_hi) return out_hi;
		if (value < out_lo) return out_lo;
		return value;
	endfunction

	function automatic int wrap_out(input int value);	// low w_out bits, signed
		logic signed [w_out-1:0] low;
		low = value[w_out-1:0];
		return int'(low);
	endfunction

	function automatic int ref_output(input int sample, input bit lock, input int prev,
		input int omax, input int omin, input int oinit, input int mult);
		int conv;
		int value;
		conv = sample;	// wider output keeps value
		if (w_out < w_in)
			conv = sample >>> (w_in - w_out);	// keep the msbs
		value = saturate(saturate(conv * mult) + prev);
		if (!lock)
			value = oinit;	// unlocked output
		if (value > omax)
			value = omax;
		if (value < omin)
			value = omin;	// min checked last
		return value;
	endfunction

	function automatic int rand_sample();
		if ($urandom_range(0, 3) == 0)	// full range now and then
			return int'($urandom_range(0, (1 << w_in) - 1)) - (1 << (w_in - 1));
		return int'($urandom_range(0, 4095)) - 2048;
	endfunction

	// cycle count and run limit
	always @(posedge clk_in) begin
		cycle++;
		if (cycle > cycle_limit) begin
			$display("timeout: test sequence not finished after %0d cycles", cycle);
			$display("Test failed");
			$fatal(1);
		end
	end

	// compare process, sampled mid cycle
	always @(negedge clk_in) begin
		int exp_out;
		if (!reset_in) begin
			if (in_flight) begin
				check_value("data_valid_out", data_valid_out, cycle == t0 + comp_latency);
				check_value("data_ready_out", data_ready_out, cycle >= t0 + comp_latency + 2);
				if (data_valid_out) begin
					exp_out = ref_output(cap_sample, cap_lock, prev_model,
						act_max, act_min, act_init, act_mult);
					check_value("data_out", data_out, exp_out);
					prev_model = exp_out;	// feeds next sample
					last_out = int'(data_out);
					n_out++;
				end
				if (cycle >= t0 + comp_latency + 2)
					in_flight = 1'b0;
			end else begin
				check_value("data_valid_out", data_valid_out, 0);
				check_value("data_ready_out", data_ready_out, 1);
			end
			if (data_valid_in && data_ready_out) begin	// transfer at next edge
				t0 = cycle + 1;
				in_flight = 1'b1;
				cap_sample = int'(data_in);
				cap_lock = lock_en_in;
				n_acc++;
			end
		end
	end

	//////////////////////////////////////////////////
	// bus and sample tasks
	//////////////////////////////////////////////////

	task automatic axi_write(input logic [opp_cfg_pkg::axi_addr_w-1:0] addr, input int data,
		input logic [1:0] exp_resp, input int hold_cycles);
		@(posedge clk_in);
		#1;
		s_axi_awaddr = addr;
		s_axi_wdata = data;
		s_axi_awvalid = 1'b1;
		s_axi_wvalid = 1'b1;
		s_axi_bready = 1'b0;
		@(negedge clk_in);
		while (!s_axi_awready) @(negedge clk_in);
		check_value("s_axi_wready", s_axi_wready, 1);
		@(posedge clk_in);
		#1;
		s_axi_awvalid = 1'b0;
		s_axi_wvalid = 1'b0;
		@(negedge clk_in);
		check_value("s_axi_bvalid", s_axi_bvalid, 1);	// one cycle after handshake
		repeat (hold_cycles) begin
			@(negedge clk_in);
			check_value("s_axi_bvalid", s_axi_bvalid, 1);	// held while bready low
		end
		@(posedge clk_in);
		#1;
		s_axi_bready = 1'b1;
		@(negedge clk_in);
		check_value("s_axi_bresp", s_axi_bresp, exp_resp);
		@(posedge clk_in);
		#1;
		s_axi_bready = 1'b0;
		@(negedge clk_in);
		check_value("s_axi_bvalid", s_axi_bvalid, 0);
	endtask

	task automatic read_check(input logic [opp_cfg_pkg::axi_addr_w-1:0] addr,
		input int exp_data, input logic [1:0] exp_resp);
		@(posedge clk_in);
		#1;
		s_axi_araddr = addr;
		s_axi_arvalid = 1'b1;
		s_axi_rready = 1'b1;
		@(negedge clk_in);
		while (!s_axi_arready) @(negedge clk_in);
		@(posedge clk_in);
		#1;
		s_axi_arvalid = 1'b0;
		@(negedge clk_in);
		check_value("s_axi_rvalid", s_axi_rvalid, 1);
		check_value("s_axi_rdata", s_axi_rdata, exp_data);
		check_value("s_axi_rresp", s_axi_rresp, exp_resp);
		@(posedge clk_in);
		#1;
		s_axi_rready = 1'b0;
	endtask

	task automatic write_reg(input logic [opp_cfg_pkg::axi_addr_w-1:0] addr, input int value,
		input int hold_cycles);
		axi_write(addr, value, okay, hold_cycles);
		case (addr)
			opp_cfg_pkg::reg_out_max:  stg_max = wrap_out(value);
			opp_cfg_pkg::reg_out_min:  stg_min = wrap_out(value);
			opp_cfg_pkg::reg_out_init: stg_init = wrap_out(value);
			opp_cfg_pkg::reg_mult:     stg_mult = value & ((1 << opp_data_pkg::mult_w) - 1);
			default: ;
		endcase
	endtask

	task automatic apply_cfg();	// only called while idle
		axi_write(opp_cfg_pkg::reg_apply, 0, okay, 0);
		act_max = stg_max;
		act_min = stg_min;
		act_init = stg_init;
		act_mult = stg_mult;
		prev_model = stg_init;	// restart value
	endtask

	task automatic offer_sample(input int sample, input bit lock);
		@(posedge clk_in);
		#1;
		data_in = sample[w_in-1:0];
		lock_en_in = lock;
		data_valid_in = 1'b1;
		@(negedge clk_in);
		while (!data_ready_out) @(negedge clk_in);	// held while busy
		@(posedge clk_in);
		#1;
		data_valid_in = 1'b0;
	endtask

	task automatic wait_idle();
		@(negedge clk_in);
		while (n_out != n_acc || !data_ready_out) @(negedge clk_in);
	endtask

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	initial begin
		int g;
		void'($urandom(17));
		data_in = '0;
		data_valid_in = 1'b0;
		lock_en_in = 1'b0;
		s_axi_awaddr = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wstrb = '1;	// full word writes
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b0;
		s_axi_araddr = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		wait (!reset_in);

		// reset values, unlocked output is init
		read_check(opp_cfg_pkg::reg_out_max, omax_init, okay);
		read_check(opp_cfg_pkg::reg_out_min, omin_init, okay);
		read_check(opp_cfg_pkg::reg_out_init, oinit_init, okay);
		read_check(opp_cfg_pkg::reg_mult, mult_init, okay);
		offer_sample(rand_sample(), 1'b0);
		wait_idle();
		check_value("data_out", last_out, oinit_init);

		repeat (3) offer_sample(rand_sample(), 1'b1);	// back to back, held while busy
		wait_idle();

		// accumulation, groups of random gain
		write_reg(opp_cfg_pkg::reg_out_max, 30000, 0);
		write_reg(opp_cfg_pkg::reg_out_min, -30000, 0);
		for (g = 0; g < 10; g++) begin
			write_reg(opp_cfg_pkg::reg_out_init, int'($urandom_range(0, 2000)) - 1000, 0);
			write_reg(opp_cfg_pkg::reg_mult, $urandom_range(0, 7), 0);
			apply_cfg();
			repeat (20) offer_sample(rand_sample(), 1'b1);
			wait_idle();
		end

		// saturation at full range bounds
		write_reg(opp_cfg_pkg::reg_out_max, out_hi, 0);
		write_reg(opp_cfg_pkg::reg_out_min, out_lo, 0);
		write_reg(opp_cfg_pkg::reg_mult, 255, 0);
		apply_cfg();
		repeat (3) offer_sample((1 << (w_in - 1)) - 1, 1'b1);
		repeat (6) offer_sample(-(1 << (w_in - 1)), 1'b1);
		wait_idle();
		check_value("data_out", last_out, out_lo);	// pinned at most negative

		// narrow, then crossed bounds
		write_reg(opp_cfg_pkg::reg_out_max, 100, 0);
		write_reg(opp_cfg_pkg::reg_out_min, -100, 0);
		write_reg(opp_cfg_pkg::reg_mult, 3, 0);
		apply_cfg();
		repeat (5) offer_sample(rand_sample(), 1'b1);
		write_reg(opp_cfg_pkg::reg_out_max, -50, 0);
		write_reg(opp_cfg_pkg::reg_out_min, 50, 0);
		wait_idle();
		apply_cfg();
		repeat (4) offer_sample(rand_sample(), 1'b1);
		offer_sample(rand_sample(), 1'b0);
		wait_idle();
		check_value("data_out", last_out, 50);	// lower bound wins

		// staged values stay inactive until apply
		write_reg(opp_cfg_pkg::reg_out_max, 30000, 0);
		write_reg(opp_cfg_pkg::reg_out_min, -30000, 0);
		write_reg(opp_cfg_pkg::reg_out_init, 1234, 0);
		write_reg(opp_cfg_pkg::reg_mult, 0, 0);
		read_check(opp_cfg_pkg::reg_out_init, 1234, okay);
		repeat (2) offer_sample(rand_sample(), 1'b0);	// staged init must not show yet
		wait_idle();
		check_value("data_out", last_out, 50);
		apply_cfg();
		offer_sample(rand_sample(), 1'b1);	// zero gain shows previous output
		wait_idle();
		check_value("data_out", last_out, 1234);

		// axi corner cases
		axi_write(5'h14, 32'h0000_1234, slverr, 0);
		axi_write(5'h02, 32'h0000_0042, slverr, 0);	// unaligned
		read_check(5'h14, 0, slverr);
		read_check(5'h1C, 0, slverr);
		read_check(opp_cfg_pkg::reg_apply, 0, okay);
		read_check(opp_cfg_pkg::reg_out_max, stg_max, okay);	// untouched by bad writes
		write_reg(opp_cfg_pkg::reg_out_init, -777, 5);	// bready held low
		read_check(opp_cfg_pkg::reg_out_init, -777, okay);
		offer_sample(rand_sample(), 1'b1);
		wait_idle();

		if (n_acc != n_out || n_acc == 0) begin
			$display("sample count mismatch: %0d accepted, %0d emitted", n_acc, n_out);
			$display("Test failed");
			$fatal(1);
		end else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
	parameter int reset_cycles = 8	// rising edges with reset high
) (
	output logic clk_in,
	output logic reset_in
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_in = 1'b0;
		forever #2 clk_in = ~clk_in;	// 4 ns period
	end

	initial begin
		reset_in = 1'b1;
		repeat (reset_cycles) @(posedge clk_in);
		#1 reset_in = 1'b0;	// released off the edge
	end

endmodule

`default_nettype wire

// ==== rtl/output_preprocessor.sv ====
`default_nettype none

module output_preprocessor #(
	parameter int w_in         = 18,
	parameter int w_out        = 16,
	parameter int comp_latency = 3,
	parameter int omax_init    = 9999,
	parameter int omin_init    = 1111,
	parameter int oinit_init   = 5000,
	parameter int mult_init    = 1
) (
	input  logic                                 clk_in,
	input  logic                                 reset_in,
	// upstream samples
	input  logic signed [w_in-1:0]               data_in,
	input  logic                                 data_valid_in,
	output logic                                 data_ready_out,
	input  logic                                 lock_en_in,
	// downstream, always accepted
	output logic signed [w_out-1:0]              data_out,
	output logic                                 data_valid_out,
	// axi4-lite configuration slave
	input  logic [opp_cfg_pkg::axi_addr_w-1:0]   s_axi_awaddr,
	input  logic                                 s_axi_awvalid,
	output logic                                 s_axi_awready,
	input  logic [opp_cfg_pkg::axi_data_w-1:0]   s_axi_wdata,
	input  logic [opp_cfg_pkg::axi_data_w/8-1:0] s_axi_wstrb,
	input  logic                                 s_axi_wvalid,
	output logic                                 s_axi_wready,
	output logic [1:0]                           s_axi_bresp,
	output logic                                 s_axi_bvalid,
	input  logic                                 s_axi_bready,
	input  logic [opp_cfg_pkg::axi_addr_w-1:0]   s_axi_araddr,
	input  logic                                 s_axi_arvalid,
	output logic                                 s_axi_arready,
	output logic [opp_cfg_pkg::axi_data_w-1:0]   s_axi_rdata,
	output logic [1:0]                           s_axi_rresp,
	output logic                                 s_axi_rvalid,
	input  logic                                 s_axi_rready
);

	opp_cfg_if   #(.w_out(w_out)) cfg_bus ();	// active configuration
	opp_stage_if #(.w_out(w_out)) stg_bus ();	// sequencer and stages

	logic signed [w_out-1:0] product;	// gain stage to accum stage

	opp_cfg_regs #(
		.w_out(w_out), .omax_init(omax_init), .omin_init(omin_init),
		.oinit_init(oinit_init), .mult_init(mult_init)
	) u_cfg_regs (
		.clk_in, .reset_in,
		.s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
		.s_axi_wdata, .s_axi_wstrb, .s_axi_wvalid, .s_axi_wready,
		.s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
		.s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
		.s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready,
		.cfg(cfg_bus.source)
	);

	opp_sequencer #(.comp_latency(comp_latency)) u_sequencer (
		.clk_in, .reset_in, .data_valid_in, .data_ready_out, .data_valid_out,
		.stg(stg_bus.ctrl)
	);

	opp_gain_stage #(.w_in(w_in), .w_out(w_out)) u_gain_stage (
		.clk_in, .reset_in, .data_in, .lock_en_in, .product,
		.stg(stg_bus.gain), .cfg(cfg_bus.sink)
	);

	opp_accum_stage #(.w_out(w_out), .oinit_init(oinit_init)) u_accum_stage (
		.clk_in, .reset_in, .product,
		.stg(stg_bus.accum), .cfg(cfg_bus.sink)
	);

	assign data_out = stg_bus.result;	// valid while data_valid_out

endmodule

`default_nettype wire

// ==== rtl/opp_accum_stage.sv ====
`default_nettype none

module opp_accum_stage #(
	parameter int w_out      = 16,
	parameter int oinit_init = 5000	// previous output after reset
) (
	input  logic                    clk_in,
	input  logic                    reset_in,
	input  logic signed [w_out-1:0] product,
	opp_stage_if.accum              stg,
	opp_cfg_if.sink                 cfg
);

	localparam logic signed [w_out-1:0] out_hi = {1'b0, {(w_out-1){1'b1}}};
	localparam logic signed [w_out-1:0] out_lo = {1'b1, {(w_out-1){1'b0}}};

	logic signed [w_out-1:0] prev_q;	// last emitted output
	logic signed [w_out:0]   sum_full;	// one guard bit
	logic signed [w_out-1:0] sum_sat;
	logic signed [w_out-1:0] locked;	// after lock select
	logic signed [w_out-1:0] upper;	// after max clamp

	//////////////////////////////////////////////////
	// add, select, clamp
	//////////////////////////////////////////////////

	assign sum_full = (w_out+1)'(product) + (w_out+1)'(prev_q);

	always_comb begin
		if (sum_full[w_out] == sum_full[w_out-1])
			sum_sat = sum_full[w_out-1:0];
		else if (sum_full[w_out])
			sum_sat = out_lo;	// negative overflow
		else
			sum_sat = out_hi;
	end

	assign locked = stg.lock ? sum_sat : cfg.out_init;	// unlocked holds init
	assign upper  = (locked > cfg.out_max) ? cfg.out_max : locked;
	assign stg.result = (upper < cfg.out_min) ? cfg.out_min : upper;	// min has last word

	// previous output register
	always_ff @(posedge clk_in) begin
		if (reset_in)
			prev_q <= w_out'(oinit_init);
		else if (cfg.apply)
			prev_q <= cfg.out_init;	// restart from new init
		else if (stg.commit)
			prev_q <= stg.result;
	end

	// apply only expected while the sequencer is idle
	a_no_apply_commit: assert property (@(posedge clk_in) disable iff (reset_in)
		!(stg.commit && cfg.apply))
		else $warning("apply during commit, previous output takes init value");

endmodule

`default_nettype wire

// ==== rtl/opp_gain_stage.sv ====
`default_nettype none

module opp_gain_stage #(
	parameter int w_in  = 18,
	parameter int w_out = 16
) (
	input  logic                    clk_in,
	input  logic                    reset_in,
	input  logic signed [w_in-1:0]  data_in,
	input  logic                    lock_en_in,
	output logic signed [w_out-1:0] product,	// saturated sample * gain
	opp_stage_if.gain               stg,
	opp_cfg_if.sink                 cfg
);

	localparam int prod_w = w_out + opp_data_pkg::mult_w + 1;	// full precision, signed

	logic signed [w_out-1:0]  conv;	// width converted input
	logic signed [prod_w-1:0] sample_ext, mult_ext, prod_full;
	logic [opp_data_pkg::mult_w+1:0] prod_top;	// bits above the output msb
	logic                     in_range;

	// narrower output keeps the msbs, wider sign extends
	if (w_out < w_in) begin : g_trunc
		assign conv = data_in[w_in-1 -: w_out];
	end else begin : g_ext
		assign conv = w_out'(data_in);
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			stg.sample <= '0;
			stg.lock   <= 1'b0;
		end else if (stg.capture) begin
			stg.sample <= conv;
			stg.lock   <= lock_en_in;	// taken on the same edge
		end
	end

	//////////////////////////////////////////////////
	// saturating multiply
	//////////////////////////////////////////////////

	assign sample_ext = prod_w'(stg.sample);
	assign mult_ext   = prod_w'({1'b0, cfg.mult});	// gain is unsigned
	assign prod_full  = sample_ext * mult_ext;
	assign prod_top   = prod_full[prod_w-1:w_out-1];
	assign in_range   = (&prod_top) || !(|prod_top);	// all sign copies agree

	always_comb begin
		if (in_range)
			product = prod_full[w_out-1:0];
		else if (prod_full[prod_w-1])
			product = {1'b1, {(w_out-1){1'b0}}};	// most negative
		else
			product = {1'b0, {(w_out-1){1'b1}}};	// most positive
	end

endmodule

`default_nettype wire

// ==== rtl/opp_sequencer.sv ====
`default_nettype none

module opp_sequencer #(
	parameter int comp_latency = 3	// cycles in st_compute, at least 1
) (
	input  logic         clk_in,
	input  logic         reset_in,
	input  logic         data_valid_in,
	output logic         data_ready_out,
	output logic         data_valid_out,
	opp_stage_if.ctrl    stg
);

	localparam int cnt_w = (comp_latency > 1) ? $clog2(comp_latency) : 1;
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(comp_latency - 1);

	//////////////////////////////////////////////////
	// state and intrastate counter
	//////////////////////////////////////////////////

	opp_data_pkg::seq_state_e state;
	logic [cnt_w-1:0]         cnt;	// cycles spent in st_compute

	assign stg.capture    = data_valid_in && (state == opp_data_pkg::st_idle);
	assign stg.commit     = (state == opp_data_pkg::st_done);
	assign data_ready_out = (state == opp_data_pkg::st_idle);
	assign data_valid_out = (state == opp_data_pkg::st_send);	// one cycle per sample

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state <= opp_data_pkg::st_idle;
			cnt   <= '0;
		end else begin
			case (state)
				opp_data_pkg::st_idle: begin
					cnt <= '0;
					if (stg.capture)
						state <= opp_data_pkg::st_compute;	// sample taken this edge
				end
				opp_data_pkg::st_compute: begin
					if (cnt == cnt_last) begin
						cnt   <= '0;
						state <= opp_data_pkg::st_send;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				opp_data_pkg::st_send: state <= opp_data_pkg::st_done;
				opp_data_pkg::st_done: state <= opp_data_pkg::st_idle;	// prev output loads here
				default:               state <= opp_data_pkg::st_idle;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// capture only from idle, so never two in a row
	a_capture_idle: assert property (@(posedge clk_in) disable iff (reset_in)
		stg.capture |=> (state == opp_data_pkg::st_compute) && !stg.capture);

	// output strobe is a single cycle
	a_valid_pulse: assert property (@(posedge clk_in) disable iff (reset_in)
		data_valid_out |=> !data_valid_out);

endmodule

`default_nettype wire

// ==== rtl/opp_cfg_regs.sv ====
`default_nettype none

module opp_cfg_regs #(
	parameter int w_out     = 16,
	parameter int omax_init = 9999,
	parameter int omin_init = 1111,
	parameter int oinit_init = 5000,
	parameter int mult_init = 1
) (
	input  logic                                   clk_in,
	input  logic                                   reset_in,
	input  logic [opp_cfg_pkg::axi_addr_w-1:0]     s_axi_awaddr,
	input  logic                                   s_axi_awvalid,
	output logic                                   s_axi_awready,
	input  logic [opp_cfg_pkg::axi_data_w-1:0]     s_axi_wdata,
	input  logic [opp_cfg_pkg::axi_data_w/8-1:0]   s_axi_wstrb,	// full word writes only
	input  logic                                   s_axi_wvalid,
	output logic                                   s_axi_wready,
	output logic [1:0]                             s_axi_bresp,
	output logic                                   s_axi_bvalid,
	input  logic                                   s_axi_bready,
	input  logic [opp_cfg_pkg::axi_addr_w-1:0]     s_axi_araddr,
	input  logic                                   s_axi_arvalid,
	output logic                                   s_axi_arready,
	output logic [opp_cfg_pkg::axi_data_w-1:0]     s_axi_rdata,
	output logic [1:0]                             s_axi_rresp,
	output logic                                   s_axi_rvalid,
	input  logic                                   s_axi_rready,
	opp_cfg_if.source                              cfg
);

	localparam int dw = opp_cfg_pkg::axi_data_w;
	localparam int mw = opp_data_pkg::mult_w;

	//////////////////////////////////////////////////
	// staged and active copies
	//////////////////////////////////////////////////

	logic signed [w_out-1:0] stg_max, stg_min, stg_init;	// written over axi
	logic        [mw-1:0]    stg_mult;
	logic signed [w_out-1:0] act_max, act_min, act_init;	// used by datapath
	logic        [mw-1:0]    act_mult;
	logic                    apply_q;	// apply strobe

	logic                    awready_q;	// aw and w accepted together
	logic                    bvalid_q;
	opp_cfg_pkg::axi_resp_e  bresp_q;
	logic                    arready_q;
	logic                    rvalid_q;
	logic [dw-1:0]           rdata_q;
	opp_cfg_pkg::axi_resp_e  rresp_q;
	logic                    wr_fire, rd_fire;	// handshake edges

	assign wr_fire = awready_q && s_axi_awvalid && s_axi_wvalid;
	assign rd_fire = arready_q && s_axi_arvalid;

	// write channel, staged stores and apply
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			awready_q <= 1'b0;
			bvalid_q  <= 1'b0;
			bresp_q   <= opp_cfg_pkg::resp_okay;
			apply_q   <= 1'b0;
			stg_max   <= w_out'(omax_init);
			stg_min   <= w_out'(omin_init);
			stg_init  <= w_out'(oinit_init);
			stg_mult  <= mw'(mult_init);
			act_max   <= w_out'(omax_init);
			act_min   <= w_out'(omin_init);
			act_init  <= w_out'(oinit_init);
			act_mult  <= mw'(mult_init);
		end else begin
			apply_q   <= 1'b0;	// single cycle pulse
			awready_q <= s_axi_awvalid && s_axi_wvalid && !bvalid_q && !awready_q;
			if (bvalid_q && s_axi_bready)
				bvalid_q <= 1'b0;
			if (wr_fire) begin
				bvalid_q <= 1'b1;
				bresp_q  <= opp_cfg_pkg::resp_okay;
				case (s_axi_awaddr)
					opp_cfg_pkg::reg_out_max:  stg_max  <= s_axi_wdata[w_out-1:0];
					opp_cfg_pkg::reg_out_min:  stg_min  <= s_axi_wdata[w_out-1:0];
					opp_cfg_pkg::reg_out_init: stg_init <= s_axi_wdata[w_out-1:0];
					opp_cfg_pkg::reg_mult:     stg_mult <= s_axi_wdata[mw-1:0];
					opp_cfg_pkg::reg_apply: begin
						apply_q  <= 1'b1;	// accum reloads next edge
						act_max  <= stg_max;
						act_min  <= stg_min;
						act_init <= stg_init;
						act_mult <= stg_mult;
					end
					default: bresp_q <= opp_cfg_pkg::resp_slverr;	// nothing stored
				endcase
			end
		end
	end

	// read channel returns staged values
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			arready_q <= 1'b0;
			rvalid_q  <= 1'b0;
			rdata_q   <= '0;
			rresp_q   <= opp_cfg_pkg::resp_okay;
		end else begin
			arready_q <= s_axi_arvalid && !rvalid_q && !arready_q;
			if (rvalid_q && s_axi_rready)
				rvalid_q <= 1'b0;
			if (rd_fire) begin
				rvalid_q <= 1'b1;
				rresp_q  <= opp_cfg_pkg::resp_okay;
				case (s_axi_araddr)
					opp_cfg_pkg::reg_out_max:  rdata_q <= dw'(stg_max);	// sign extended
					opp_cfg_pkg::reg_out_min:  rdata_q <= dw'(stg_min);
					opp_cfg_pkg::reg_out_init: rdata_q <= dw'(stg_init);
					opp_cfg_pkg::reg_mult:     rdata_q <= dw'(stg_mult);
					opp_cfg_pkg::reg_apply:    rdata_q <= '0;
					default: begin
						rdata_q <= '0;
						rresp_q <= opp_cfg_pkg::resp_slverr;
					end
				endcase
			end
		end
	end

	assign s_axi_awready = awready_q;
	assign s_axi_wready  = awready_q;	// both channels taken at once
	assign s_axi_bvalid  = bvalid_q;
	assign s_axi_bresp   = bresp_q;
	assign s_axi_arready = arready_q;
	assign s_axi_rvalid  = rvalid_q;
	assign s_axi_rdata   = rdata_q;
	assign s_axi_rresp   = rresp_q;

	assign cfg.out_max  = act_max;
	assign cfg.out_min  = act_min;
	assign cfg.out_init = act_init;
	assign cfg.mult     = act_mult;
	assign cfg.apply    = apply_q;

	// write response held until the master takes it
	a_bvalid_hold: assert property (@(posedge clk_in) disable iff (reset_in)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

endmodule

`default_nettype wire

// ==== rtl/opp_stage_if.sv ====
`default_nettype none

// sequencer strobes plus the data handed between stages
interface opp_stage_if #(
	parameter int w_out = 16	// output sample width
);

	logic                    capture;	// sample taken this edge
	logic                    commit;	// latch result as previous output
	logic signed [w_out-1:0] sample;	// width converted sample
	logic                    lock;		// lock flag taken with the sample
	logic signed [w_out-1:0] result;	// clamped output value

	modport ctrl (
		output capture, commit
	);

	modport gain (
		input  capture,
		output sample, lock
	);

	modport accum (
		input  commit, lock,
		output result
	);

endinterface

`default_nettype wire

// ==== rtl/opp_cfg_if.sv ====
`default_nettype none

// active configuration, register block to datapath
interface opp_cfg_if #(
	parameter int w_out = 16	// output sample width
);

	logic signed [w_out-1:0]              out_max;	// active upper bound
	logic signed [w_out-1:0]              out_min;	// active lower bound
	logic signed [w_out-1:0]              out_init;	// restart / unlocked value
	logic        [opp_data_pkg::mult_w-1:0] mult;	// active gain
	logic                                 apply;	// one cycle after apply write

	// register block side
	modport source (
		output out_max, out_min, out_init, mult, apply
	);

	// datapath stages
	modport sink (
		input out_max, out_min, out_init, mult, apply
	);

endinterface

`default_nettype wire

// ==== rtl/opp_data_pkg.sv ====
`default_nettype none

package opp_data_pkg;

	//////////////////////////////////////////////////
	// sample side definitions
	//////////////////////////////////////////////////

	localparam int mult_w = 8;	// unsigned gain width

	// one sample in flight, four phases
	typedef enum logic [1:0] {
		st_idle    = 2'd0,	// waiting for valid upstream data
		st_compute = 2'd1,	// datapath settling, comp_latency cycles
		st_send    = 2'd2,	// result presented downstream
		st_done    = 2'd3	// previous output latched
	} seq_state_e;

endpackage

`default_nettype wire

// ==== rtl/opp_cfg_pkg.sv ====
`default_nettype none

package opp_cfg_pkg;

	//////////////////////////////////////////////////
	// axi4-lite bus geometry
	//////////////////////////////////////////////////

	localparam int axi_addr_w = 5;	// byte address, 8 word slots
	localparam int axi_data_w = 32;	// full word data path

	//////////////////////////////////////////////////
	// register map
	//////////////////////////////////////////////////

	localparam logic [axi_addr_w-1:0] reg_out_max  = 5'h00;	// staged upper bound
	localparam logic [axi_addr_w-1:0] reg_out_min  = 5'h04;	// staged lower bound
	localparam logic [axi_addr_w-1:0] reg_out_init = 5'h08;	// staged restart value
	localparam logic [axi_addr_w-1:0] reg_mult     = 5'h0C;	// staged gain
	localparam logic [axi_addr_w-1:0] reg_apply    = 5'h10;	// write only, reads zero

	// response codes as seen on bresp / rresp
	typedef enum logic [1:0] {
		resp_okay   = 2'b00,	// normal access
		resp_slverr = 2'b10	// unmapped address
	} axi_resp_e;

endpackage

`default_nettype wire
